// ==== mm_settings.svh ====
// Build-time sizes for the matrix multiply subsystem
// MM_ROWS and MM_COLS must be multiples of MM_BLOCK, with at least two blocks each
// Elements are signed fixed point with MM_FRAC fraction bits
`ifndef MM_SETTINGS_SVH
`define MM_SETTINGS_SVH

// Element format
`define MM_WIDTH 16   // Element width, Q8.8
`define MM_FRAC  8    // Fraction bits dropped after accumulation

// Array size, B x B PEs
`define MM_BLOCK 2

// Matrix shapes, I is ROWS x INNER and W is COLS x INNER
`define MM_INNER 4
`define MM_ROWS  4
`define MM_COLS  6

// Accumulator, wraps on overflow
`define MM_ACC_W 32

`endif

// ==== mm_pkg.sv ====
// Shared types for the matrix multiply
// All sizes derive from mm_settings.svh, word slot 0 sits in the low bits
`include "mm_settings.svh"

package mm_pkg;

    // Memory depths in words
    localparam int IN_DEPTH  = (`MM_ROWS / `MM_BLOCK) * `MM_INNER;
    localparam int WT_DEPTH  = (`MM_COLS / `MM_BLOCK) * `MM_INNER;
    localparam int OUT_DEPTH = `MM_ROWS * (`MM_COLS / `MM_BLOCK);

    // Sequencer FSM
    typedef enum logic [1:0] {
        IDLE,
        FEED,
        DRAIN,
        WRITE
    } seq_state_t;

    typedef logic [`MM_BLOCK*`MM_WIDTH-1:0] word_t;    // B elements per word
    typedef logic signed [`MM_WIDTH-1:0]     elem_t;
    typedef logic [$clog2(IN_DEPTH)-1:0]     in_addr_t;
    typedef logic [$clog2(WT_DEPTH)-1:0]     wt_addr_t;
    typedef logic [$clog2(OUT_DEPTH)-1:0]    out_addr_t;
    typedef logic [$clog2(`MM_BLOCK)-1:0]    row_idx_t; // Row inside a tile

endpackage

// ==== tile_ram.sv ====
// Inferred simple dual-port RAM, one word holds MM_BLOCK elements
// Read data is registered and valid one cycle after raddr
// Contents power up unknown, same-address read returns the old word
`timescale 1ns/1ns

module tile_ram #(
    parameter int DEPTH = 8,
    parameter int AW    = 3
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  mm_pkg::word_t wdata,
    input  logic [AW-1:0] raddr,
    output mm_pkg::word_t rdata
);
    import mm_pkg::*;

    word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== pe_mac.sv ====
// One cell of the output-stationary array, signed multiply-accumulate
// Accumulator wraps, no saturation; operands pass on after one cycle
`timescale 1ns/1ns
`include "mm_settings.svh"

module pe_mac (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mm_pkg::elem_t               a_in,
    input  mm_pkg::elem_t               b_in,
    input  logic                        valid_in,
    input  logic                        first_in,
    input  logic                        last_in,
    output mm_pkg::elem_t               a_out,
    output mm_pkg::elem_t               b_out,
    output logic                        valid_out,
    output logic                        first_out,
    output logic                        last_out,
    output logic signed [`MM_ACC_W-1:0] acc
);

    logic signed [`MM_ACC_W-1:0] prod;

    assign prod = a_in * b_in; // Full precision, sign extended

    // Operands and accumulator
    always_ff @(posedge clk) begin
        a_out <= a_in; // East
        b_out <= b_in; // South
        if (valid_in) begin
            // First k-step starts a new tile
            acc <= first_in ? prod : acc + prod;
        end
    end

    // Tags travel east with a
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            first_out <= 1'b0;
            last_out  <= 1'b0;
        end else begin
            valid_out <= valid_in;
            first_out <= first_in;
            last_out  <= last_in;
        end
    end

endmodule

// ==== systolic_block.sv ====
// B x B output-stationary array, PE(i,j) sees k-step k at skew i+j
// Results are held until the next first-tagged step reaches each PE
// row_data is combinational from row_sel, Q8.8 by arithmetic shift and truncate
`timescale 1ns/1ns
`include "mm_settings.svh"

module systolic_block (
    input  logic             clk,
    input  logic             rst_n,
    input  mm_pkg::word_t    west_data,
    input  mm_pkg::word_t    north_data,
    input  logic             feed_valid,
    input  logic             feed_first,
    input  logic             feed_last,
    input  mm_pkg::row_idx_t row_sel,
    output mm_pkg::word_t    row_data,
    output logic             tile_done
);
    import mm_pkg::*;

    localparam int B = `MM_BLOCK;

    // Links between cells, one extra column east and row south
    elem_t a_net [B][B+1];
    elem_t b_net [B+1][B];
    logic  v_net [B][B+1];
    logic  f_net [B][B+1];
    logic  l_net [B][B+1];
    logic signed [`MM_ACC_W-1:0] acc_q [B][B];

    genvar i, j;
    generate
        // West edge, row i delayed i cycles together with its tags
        for (i = 0; i < B; i++) begin : g_west
            if (i == 0) begin : g_direct
                assign a_net[i][0] = west_data[0 +: `MM_WIDTH];
                assign v_net[i][0] = feed_valid;
                assign f_net[i][0] = feed_first;
                assign l_net[i][0] = feed_last;
            end else begin : g_skew
                elem_t      a_sk [i];
                logic [2:0] t_sk [i]; // valid, first, last
                always_ff @(posedge clk) begin
                    a_sk[0] <= west_data[i*`MM_WIDTH +: `MM_WIDTH];
                    for (int d = 1; d < i; d++) begin
                        a_sk[d] <= a_sk[d-1];
                    end
                end
                always_ff @(posedge clk) begin
                    if (!rst_n) begin
                        for (int d = 0; d < i; d++) begin
                            t_sk[d] <= 3'b000;
                        end
                    end else begin
                        t_sk[0] <= {feed_valid, feed_first, feed_last};
                        for (int d = 1; d < i; d++) begin
                            t_sk[d] <= t_sk[d-1];
                        end
                    end
                end
                assign a_net[i][0] = a_sk[i-1];
                assign {v_net[i][0], f_net[i][0], l_net[i][0]} = t_sk[i-1];
            end
        end

        // North edge, column j delayed j cycles
        for (j = 0; j < B; j++) begin : g_north
            if (j == 0) begin : g_direct
                assign b_net[0][j] = north_data[0 +: `MM_WIDTH];
            end else begin : g_skew
                elem_t b_sk [j];
                always_ff @(posedge clk) begin
                    b_sk[0] <= north_data[j*`MM_WIDTH +: `MM_WIDTH];
                    for (int d = 1; d < j; d++) begin
                        b_sk[d] <= b_sk[d-1];
                    end
                end
                assign b_net[0][j] = b_sk[j-1];
            end
        end

        // PE grid
        for (i = 0; i < B; i++) begin : g_row
            for (j = 0; j < B; j++) begin : g_col
                pe_mac u_pe (
                    .clk       (clk),
                    .rst_n     (rst_n),
                    .a_in      (a_net[i][j]),
                    .b_in      (b_net[i][j]),
                    .valid_in  (v_net[i][j]),
                    .first_in  (f_net[i][j]),
                    .last_in   (l_net[i][j]),
                    .a_out     (a_net[i][j+1]),
                    .b_out     (b_net[i+1][j]),
                    .valid_out (v_net[i][j+1]),
                    .first_out (f_net[i][j+1]),
                    .last_out  (l_net[i][j+1]),
                    .acc       (acc_q[i][j])
                );
            end
        end
    endgenerate

    // Last step has left the bottom-right PE, all sums final
    assign tile_done = v_net[B-1][B] & l_net[B-1][B];

    // Scale selected row back to Q8.8
    always_comb begin
        logic signed [`MM_ACC_W-1:0] scaled;
        row_data = '0;
        for (int c = 0; c < B; c++) begin
            scaled = acc_q[row_sel][c] >>> `MM_FRAC;        // Floor toward -inf
            row_data[c*`MM_WIDTH +: `MM_WIDTH] = scaled[`MM_WIDTH-1:0]; // Truncate
        end
    end

endmodule

// ==== tile_sequencer.sv ====
// Walks C tile by tile, column block inner, row block outer
// Per tile K feed cycles, drain until tile_done, then B row writes
// A start while busy is ignored; done pulses as busy falls
`timescale 1ns/1ns
`include "mm_settings.svh"

module tile_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              tile_done,
    output mm_pkg::in_addr_t  in_raddr,
    output mm_pkg::wt_addr_t  wt_raddr,
    output logic              feed_valid,
    output logic              feed_first,
    output logic              feed_last,
    output mm_pkg::row_idx_t  row_sel,
    output logic              out_we,
    output mm_pkg::out_addr_t out_waddr,
    output logic              busy,
    output logic              done
);
    import mm_pkg::*;

    localparam int RB_N = `MM_ROWS / `MM_BLOCK; // Row blocks
    localparam int CB_N = `MM_COLS / `MM_BLOCK; // Column blocks

    seq_state_t                   state;
    logic [$clog2(`MM_INNER)-1:0] k_cnt;
    logic [$clog2(CB_N)-1:0]      cb_cnt;
    logic [$clog2(RB_N)-1:0]      rb_cnt;
    logic                         last_k;
    logic                         last_row;
    logic                         last_tile;

    assign last_k    = (k_cnt == `MM_INNER - 1);
    assign last_row  = (row_sel == `MM_BLOCK - 1);
    assign last_tile = (cb_cnt == CB_N - 1) && (rb_cnt == RB_N - 1);

    // Read addresses, block-major then k
    assign in_raddr = in_addr_t'(rb_cnt * `MM_INNER + k_cnt);
    assign wt_raddr = wt_addr_t'(cb_cnt * `MM_INNER + k_cnt);

    // Output row r = rb*B + row_sel, column block cb
    assign out_waddr = out_addr_t'((rb_cnt * `MM_BLOCK + row_sel) * CB_N + cb_cnt);
    assign out_we    = (state == WRITE);
    assign busy      = (state != IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            k_cnt      <= '0;
            cb_cnt     <= '0;
            rb_cnt     <= '0;
            row_sel    <= '0;
            done       <= 1'b0;
            feed_valid <= 1'b0;
            feed_first <= 1'b0;
            feed_last  <= 1'b0;
        end else begin
            done <= 1'b0;
            // Tags lag the address by one cycle, same as RAM data
            feed_valid <= (state == FEED);
            feed_first <= (state == FEED) && (k_cnt == '0);
            feed_last  <= (state == FEED) && last_k;
            case (state)
                IDLE: begin
                    if (start) begin
                        cb_cnt <= '0;
                        rb_cnt <= '0;
                        k_cnt  <= '0;
                        state  <= FEED;
                    end
                end
                FEED: begin
                    if (last_k) begin
                        k_cnt <= '0;
                        state <= DRAIN;
                    end else begin
                        k_cnt <= k_cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    if (tile_done) begin
                        state <= WRITE; // row_sel already 0
                    end
                end
                WRITE: begin
                    if (!last_row) begin
                        row_sel <= row_sel + 1'b1;
                    end else begin
                        row_sel <= '0;
                        if (last_tile) begin
                            done  <= 1'b1; // Lands with busy low
                            state <= IDLE;
                        end else begin
                            state <= FEED;
                            if (cb_cnt == CB_N - 1) begin // Next row block
                                cb_cnt <= '0;
                                rb_cnt <= rb_cnt + 1'b1;
                            end else begin
                                cb_cnt <= cb_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== mm_top.sv ====
// Matrix multiply subsystem, C = I * W^T in signed Q8.8
// Load input and weight memories only while busy is low
// out_rdata is valid one cycle after out_rd_addr
`timescale 1ns/1ns

module mm_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_we,
    input  mm_pkg::in_addr_t  in_addr,
    input  mm_pkg::word_t     in_wdata,
    input  logic              wt_we,
    input  mm_pkg::wt_addr_t  wt_addr,
    input  mm_pkg::word_t     wt_wdata,
    input  logic              start,
    output logic              busy,
    output logic              done,
    input  mm_pkg::out_addr_t out_rd_addr,
    output mm_pkg::word_t     out_rdata
);
    import mm_pkg::*;

    in_addr_t  in_raddr;
    wt_addr_t  wt_raddr;
    out_addr_t out_waddr;
    word_t     in_rdata;  // West operands
    word_t     wt_rdata;  // North operands
    word_t     row_data;  // Scaled tile row
    row_idx_t  row_sel;
    logic      feed_valid;
    logic      feed_first;
    logic      feed_last;
    logic      tile_done;
    logic      out_we;

    tile_ram #(.DEPTH(IN_DEPTH), .AW($bits(in_addr_t))) in_ram (
        .clk   (clk),
        .we    (in_we),
        .waddr (in_addr),
        .wdata (in_wdata),
        .raddr (in_raddr),
        .rdata (in_rdata)
    );

    tile_ram #(.DEPTH(WT_DEPTH), .AW($bits(wt_addr_t))) wt_ram (
        .clk   (clk),
        .we    (wt_we),
        .waddr (wt_addr),
        .wdata (wt_wdata),
        .raddr (wt_raddr),
        .rdata (wt_rdata)
    );

    tile_ram #(.DEPTH(OUT_DEPTH), .AW($bits(out_addr_t))) out_ram (
        .clk   (clk),
        .we    (out_we),
        .waddr (out_waddr),
        .wdata (row_data),
        .raddr (out_rd_addr),
        .rdata (out_rdata)
    );

    tile_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .tile_done  (tile_done),
        .in_raddr   (in_raddr),
        .wt_raddr   (wt_raddr),
        .feed_valid (feed_valid),
        .feed_first (feed_first),
        .feed_last  (feed_last),
        .row_sel    (row_sel),
        .out_we     (out_we),
        .out_waddr  (out_waddr),
        .busy       (busy),
        .done       (done)
    );

    systolic_block u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .west_data  (in_rdata),
        .north_data (wt_rdata),
        .feed_valid (feed_valid),
        .feed_first (feed_first),
        .feed_last  (feed_last),
        .row_sel    (row_sel),
        .row_data   (row_data),
        .tile_done  (tile_done)
    );

endmodule

// ==== mm_chk.sv ====
// Protocol checks on the mm_top control outputs, bound into every mm_top
// Checks are off while rst_n is low
// fail_cnt counts assertion failures for the testbench summary
`timescale 1ns/1ns

module mm_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic out_we
);

    int fail_cnt = 0; // Read hierarchically by the testbench

    // Single-cycle done
    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
    else begin
        fail_cnt++;
        $error("done stayed high for more than one cycle");
    end

    // done marks the cycle busy falls, never any other
    a_done_at_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) == done)
    else begin
        fail_cnt++;
        $error("done and the falling edge of busy are not aligned");
    end

    // Output writes only inside a run
    a_we_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        out_we |-> busy)
    else begin
        fail_cnt++;
        $error("output memory written while not busy");
    end

endmodule

bind mm_top mm_chk chk_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .busy   (busy),
    .done   (done),
    .out_we (out_we)
);

// ==== mm_tb.sv ====
// Testbench for mm_top that checks C = I * W^T against a behavioral Q8.8 model
// Inputs driven 1 ns after the rising edge and outputs sampled on the falling edge
// Protocol assertions come from the bound mm_chk instance
`timescale 1ns/1ns
`include "mm_settings.svh"

module mm_tb;
    import mm_pkg::*;

    localparam int W     = `MM_WIDTH;
    localparam int B     = `MM_BLOCK;
    localparam int K     = `MM_INNER;
    localparam int ROWS  = `MM_ROWS;
    localparam int COLS  = `MM_COLS;
    localparam int RB_N  = ROWS / B;
    localparam int CB_N  = COLS / B;
    localparam int TILES = RB_N * CB_N;
    localparam int RUNS  = 5;                                // Started runs in this test
    localparam int LIMIT = RUNS * (TILES * (K + 4 * B + 4) + 50); // Watchdog limit in cycles
    // Per tile K feed cycles, 2B drain cycles and B write cycles
    localparam int RUN_BUSY = TILES * (K + 2 * B + B);

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_we;
    in_addr_t  in_addr;
    word_t     in_wdata;
    logic      wt_we;
    wt_addr_t  wt_addr;
    word_t     wt_wdata;
    logic      start;
    logic      busy;
    logic      done;
    out_addr_t out_rd_addr;
    word_t     out_rdata;

    elem_t  i_m [ROWS][K];   // Matrix I
    elem_t  w_m [COLS][K];   // Matrix W
    integer seed;
    int     data_err  = 0;
    int     ctl_err   = 0;
    int     proto_err = 0;
    int     done_cnt  = 0;
    int     busy_cnt  = 0;
    int     done_before;
    int     busy_before;

    always #4 clk = ~clk;  // 8 ns period

    mm_top mm_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_we       (in_we),
        .in_addr     (in_addr),
        .in_wdata    (in_wdata),
        .wt_we       (wt_we),
        .wt_addr     (wt_addr),
        .wt_wdata    (wt_wdata),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .out_rd_addr (out_rd_addr),
        .out_rdata   (out_rdata)
    );

    // Count done pulses and busy cycles mid-cycle
    always @(negedge clk) begin
        if (rst_n && done === 1'b1) begin
            done_cnt++;
        end
        if (rst_n && busy === 1'b1) begin
            busy_cnt++;
        end
    end

    // Watchdog
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Run timed out after %0d cycles, done never arrived", LIMIT);
        $display("Verification failed");
        $finish;
    end

    // Reference model sums full products with 32-bit wrap before >>> FRAC and truncation
    function automatic elem_t model_elem(input int r, input int c);
        logic signed [`MM_ACC_W-1:0] acc;
        logic signed [`MM_ACC_W-1:0] prod;
        acc = '0;
        for (int k = 0; k < K; k++) begin
            prod = i_m[r][k] * w_m[c][k]; // Evaluated as signed 32 bits
            acc  = acc + prod;            // Wraps
        end
        acc = acc >>> `MM_FRAC;
        return acc[W-1:0];
    endfunction

    // Identity W copies I into the first K columns
    function automatic elem_t identity_elem(input int r, input int c);
        return (c < K) ? i_m[r][c] : elem_t'(0);
    endfunction

    task automatic randomize_i();
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < K; k++) begin
                i_m[r][k] = elem_t'($random(seed)); // Full signed range
            end
        end
    endtask

    task automatic randomize_w();
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < K; k++) begin
                w_m[c][k] = elem_t'($random(seed));
            end
        end
    endtask

    task automatic fill_identity_w();
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < K; k++) begin
                w_m[c][k] = (c == k) ? elem_t'(16'h0100) : elem_t'(0); // 1.0 on diagonal
            end
        end
    endtask

    // Large mixed-sign operands whose sums overflow 16 bits before scaling
    task automatic fill_large();
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < K; k++) begin
                i_m[r][k] = ((r + k) % 2 == 1) ? elem_t'(16'h8100 + r * 'h0700 + k * 'h0130)
                                               : elem_t'(16'h7f00 - r * 'h0500 - k * 'h0210);
            end
        end
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < K; k++) begin
                w_m[c][k] = ((c + k) % 2 == 0) ? elem_t'(16'h8300 + c * 'h0110)
                                               : elem_t'(16'h7e00 - k * 'h0040);
            end
        end
    endtask

    // Write both memories in the block-major layout
    task automatic load_mems();
        for (int rb = 0; rb < RB_N; rb++) begin
            for (int k = 0; k < K; k++) begin
                @(posedge clk);
                #1;
                in_we   = 1'b1;
                in_addr = in_addr_t'(rb * K + k);
                for (int e = 0; e < B; e++) begin
                    in_wdata[e*W +: W] = i_m[rb*B + e][k]; // Slot 0 low
                end
            end
        end
        for (int cb = 0; cb < CB_N; cb++) begin
            for (int k = 0; k < K; k++) begin
                @(posedge clk);
                #1;
                in_we   = 1'b0;
                wt_we   = 1'b1;
                wt_addr = wt_addr_t'(cb * K + k);
                for (int e = 0; e < B; e++) begin
                    wt_wdata[e*W +: W] = w_m[cb*B + e][k];
                end
            end
        end
        @(posedge clk);
        #1;
        wt_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // Bounded by the watchdog
    task automatic wait_done();
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (busy === 1'b0 && done === 1'b0) else begin
                ctl_err++;
                $display("Fail busy %h done %h while idle, expected 0 0", busy, done);
            end
        end
    endtask

    // Read every output word with one cycle read latency
    task automatic check_outputs(input bit ident);
        word_t exp;
        int    c;
        for (int r = 0; r < ROWS; r++) begin
            for (int cb = 0; cb < CB_N; cb++) begin
                for (int e = 0; e < B; e++) begin
                    c = cb * B + e;
                    exp[e*W +: W] = ident ? identity_elem(r, c) : model_elem(r, c);
                end
                @(posedge clk);
                #1;
                out_rd_addr = out_addr_t'(r * CB_N + cb);
                @(posedge clk);
                @(negedge clk);
                assert (out_rdata === exp) else begin
                    data_err++;
                    $display("Fail out_rdata addr %h expected %h got %h",
                             out_rd_addr, exp, out_rdata);
                end
            end
        end
    endtask

    initial begin
        seed        = 32'h1b778f3d;
        rst_n       = 1'b0;
        in_we       = 1'b0;
        in_addr     = '0;
        in_wdata    = '0;
        wt_we       = 1'b0;
        wt_addr     = '0;
        wt_wdata    = '0;
        start       = 1'b0;
        out_rd_addr = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_idle(10); // Quiet until start

        // Random signed operands
        randomize_i();
        randomize_w();
        load_mems();
        pulse_start();
        wait_done();
        check_outputs(1'b0);

        // Identity weights so that C rows echo I
        fill_identity_w();
        load_mems();
        pulse_start();
        wait_done();
        check_outputs(1'b1);

        // Overflowing sums and negative operands
        fill_large();
        load_mems();
        pulse_start();
        wait_done();
        check_outputs(1'b0);

        // Second start mid-run must be dropped
        randomize_i();
        randomize_w();
        load_mems();
        done_before = done_cnt;
        busy_before = busy_cnt;
        pulse_start();
        repeat (3) @(negedge clk);
        assert (busy === 1'b1) else begin
            ctl_err++;
            $display("Fail busy %h during run, expected 1", busy);
        end
        pulse_start();  // Ignored
        wait_done();
        check_idle(20); // No restart
        assert (done_cnt - done_before == 1) else begin
            ctl_err++;
            $display("Fail done count %h for one run, expected 1", done_cnt - done_before);
        end
        assert (busy_cnt - busy_before == RUN_BUSY) else begin
            ctl_err++;
            $display("Fail busy cycles %h with a second start, expected %h",
                     busy_cnt - busy_before, RUN_BUSY);
        end
        check_outputs(1'b0);

        // New weights with the same I
        randomize_w();
        load_mems();
        pulse_start();
        wait_done();
        check_outputs(1'b0);

        proto_err = mm_top_inst.chk_inst.fail_cnt;
        $display("Errors: data %0d, control %0d, protocol %0d", data_err, ctl_err, proto_err);
        if (data_err + ctl_err + proto_err == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
mm_pkg.sv
tile_ram.sv
pe_mac.sv
systolic_block.sv
tile_sequencer.sv
mm_top.sv
mm_chk.sv
mm_tb.sv
